//--- Makefile
# Verilator build of the cache testbench
BIN := obj_dir/Vtb_cache
SRCS := $(shell cat sources.f)

.PHONY: run clean

run: $(BIN) ram_init.hex
	./$(BIN)

# rebuilt only when a source or the file list changes
$(BIN): sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_cache -f sources.f

clean:
	rm -rf obj_dir

//--- burst_ram.sv
/*
  read-only burst memory standing in for external ram
  contents come from ram_init.hex at start, there is no write path
  a command must only be sent while br_busy is low
  one command returns burst_count beats after a fixed latency
*/
module burst_ram (
  input  logic                                  clk_cpu,
  input  logic                                  rst,
  input  logic                                  br_cmd_en,
  input  logic [cache_pkg::burst_addr_width-1:0] br_addr,
  output logic                                  br_busy,
  output logic [cache_pkg::burst_data_width-1:0] br_rd_data,
  output logic                                  br_rd_data_valid
);

  // entry line*burst_count + k holds beat k of that line
  logic [cache_pkg::burst_data_width-1:0] mem [cache_pkg::burst_depth];

  initial begin
    $readmemh("ram_init.hex", mem);
  end

  // cycles since the command was taken
  logic [cache_pkg::burst_cnt_width-1:0] cycle_cnt;
  logic [cache_pkg::burst_cnt_width-1:0] cnt_next;
  logic [cache_pkg::burst_cnt_width-1:0] beat_off;
  logic [cache_pkg::beat_ix_width-1:0]   beat_ix;
  logic [cache_pkg::burst_addr_width-1:0] line_q;
  logic                                  busy_q;
  logic                                  valid_q;

  assign cnt_next = cycle_cnt + 1'b1;
  // beat number once the latency has passed
  assign beat_off = cnt_next - cache_pkg::burst_cnt_width'(cache_pkg::burst_read_latency);
  assign beat_ix  = beat_off[cache_pkg::beat_ix_width-1:0];

  // command accept and beat timing
  always_ff @(posedge clk_cpu) begin
    if (rst) begin
      busy_q    <= 1'b0;
      valid_q   <= 1'b0;
      cycle_cnt <= '0;
    end else if (!busy_q) begin
      valid_q <= 1'b0;
      if (br_cmd_en) begin
        busy_q    <= 1'b1;
        cycle_cnt <= '0;
      end
    end else begin
      cycle_cnt <= cnt_next;
      // valid for burst_count cycles, starting at the latency
      valid_q <= cnt_next >= cache_pkg::burst_cnt_width'(cache_pkg::burst_read_latency) &&
                 cnt_next < cache_pkg::burst_cnt_width'(cache_pkg::burst_done);
      // last beat is out, free again next cycle
      if (cnt_next == cache_pkg::burst_cnt_width'(cache_pkg::burst_done)) begin
        busy_q <= 1'b0;
      end
    end
  end

  // line address held for the whole burst
  always_ff @(posedge clk_cpu) begin
    if (!busy_q && br_cmd_en) begin
      line_q <= br_addr;
    end
  end

  // data path, only meaningful while valid is high
  always_ff @(posedge clk_cpu) begin
    br_rd_data <= mem[{line_q, beat_ix}];
  end

  assign br_busy          = busy_q;
  assign br_rd_data_valid = valid_q;

endmodule

//--- cache.sv
/*
  cpu memory subsystem top, all on clk_cpu
  port A is a byte-writable data ram with no handshake
  port B fetches instructions through the icache
  the burst ram behind the icache is internal and read-only
*/
module cache (
  input  logic                                  clk_cpu,
  input  logic                                  rst,
  // port A, data
  input  logic [cache_pkg::num_col-1:0]          we,
  input  logic [cache_pkg::data_addr_width-1:0]  addr_a,
  input  logic [cache_pkg::data_width-1:0]       din_a,
  output logic [cache_pkg::data_width-1:0]       dout_a,
  // port B, instructions
  input  logic                                  enable,
  input  logic [cache_pkg::instr_addr_width-1:0] addr_b,
  output logic [cache_pkg::instr_width-1:0]      instr,
  output logic                                  data_ready,
  output logic                                  busy
);

  // burst link between icache and burst ram
  logic                                  br_cmd_en;
  logic [cache_pkg::burst_addr_width-1:0] br_addr;
  logic                                  br_busy;
  logic [cache_pkg::burst_data_width-1:0] br_rd_data;
  logic                                  br_rd_data_valid;

  // data side, independent of the fetch path
  data_ram u_data_ram (
    .clk_cpu (clk_cpu),
    .we      (we),
    .addr_a  (addr_a),
    .din_a   (din_a),
    .dout_a  (dout_a)
  );

  // instruction side
  icache u_icache (
    .clk_cpu          (clk_cpu),
    .rst              (rst),
    .enable           (enable),
    .addr_b           (addr_b),
    .instr            (instr),
    .data_ready       (data_ready),
    .busy             (busy),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_busy          (br_busy),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  // line source for icache fills
  burst_ram u_burst_ram (
    .clk_cpu          (clk_cpu),
    .rst              (rst),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_busy          (br_busy),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

endmodule

//--- cache_pkg.sv
/*
  shared widths and geometry for the cpu memory subsystem
  a cache line must hold exactly one burst, 8 x 32 bits = 4 x 64 bits
  the burst ram must hold every line that a port B address can reach
*/
package cache_pkg;

  // port A data ram, 256 words of 4 byte lanes
  localparam int data_addr_width = 8;
  localparam int data_depth = 2 ** data_addr_width;
  localparam int num_col = 4;
  localparam int col_width = 8;
  localparam int data_width = num_col * col_width;

  // port B instruction word address
  localparam int instr_addr_width = 6;
  localparam int instr_width = 32;

  // direct-mapped geometry, address splits into tag | line index | word
  localparam int line_ix_width = 1;
  localparam int word_ix_width = 3;
  localparam int tag_width = instr_addr_width - line_ix_width - word_ix_width;
  localparam int num_lines = 2 ** line_ix_width;
  localparam int words_per_line = 2 ** word_ix_width;

  // burst ram, one command returns one full line
  localparam int burst_data_width = 64;
  localparam int burst_count = 4;
  localparam int beat_ix_width = $clog2(burst_count);
  localparam int instr_per_beat = burst_data_width / instr_width;
  localparam int burst_addr_width = 3;
  localparam int burst_depth = (2 ** burst_addr_width) * burst_count;

  // cycles from accepted command to first valid beat
  localparam int burst_read_latency = 3;
  // cycle count at which the burst is over
  localparam int burst_done = burst_read_latency + burst_count;
  localparam int burst_cnt_width = $clog2(burst_done + 1);

  // icache line fill sequence
  typedef enum logic [1:0] {
    idle,
    request,
    receive,
    deliver
  } fill_state_e;

endpackage

//--- data_ram.sv
/*
  port A data ram, single port, byte lane write enables
  read is registered and returns the word as it was before the write
  contents are not reset, a read of an unwritten word returns x
*/
module data_ram (
  input  logic                                clk_cpu,
  input  logic [cache_pkg::num_col-1:0]         we,
  input  logic [cache_pkg::data_addr_width-1:0] addr_a,
  input  logic [cache_pkg::data_width-1:0]      din_a,
  output logic [cache_pkg::data_width-1:0]      dout_a
);

  // word storage, maps onto one block ram
  logic [cache_pkg::data_width-1:0] mem [cache_pkg::data_depth];

  // byte lane writes
  always_ff @(posedge clk_cpu) begin
    for (int i = 0; i < cache_pkg::num_col; i++) begin
      // each lane only touches its own 8 bits
      if (we[i]) begin
        mem[addr_a][i*cache_pkg::col_width +: cache_pkg::col_width] <=
          din_a[i*cache_pkg::col_width +: cache_pkg::col_width];
      end
    end
  end

  // registered read
  // nonblocking, so the old word is returned on a write cycle
  always_ff @(posedge clk_cpu) begin
    dout_a <= mem[addr_a];
  end

endmodule

//--- icache.sv
/*
  direct-mapped read-only instruction cache for port B
  enable is a one cycle pulse and is only taken while busy is low
  hit answers next cycle, miss fills a whole line from the burst ram
  instr is only meaningful in the cycle where data_ready is high
*/
module icache (
  input  logic                                  clk_cpu,
  input  logic                                  rst,
  // port B requester
  input  logic                                  enable,
  input  logic [cache_pkg::instr_addr_width-1:0] addr_b,
  output logic [cache_pkg::instr_width-1:0]      instr,
  output logic                                  data_ready,
  output logic                                  busy,
  // burst ram link
  output logic                                  br_cmd_en,
  output logic [cache_pkg::burst_addr_width-1:0] br_addr,
  input  logic                                  br_busy,
  input  logic [cache_pkg::burst_data_width-1:0] br_rd_data,
  input  logic                                  br_rd_data_valid
);

  // index width of the flat line storage, line index | word
  localparam int store_ix_width = cache_pkg::line_ix_width + cache_pkg::word_ix_width;
  localparam int half_width = cache_pkg::word_ix_width - cache_pkg::beat_ix_width;

  cache_pkg::fill_state_e state;

  // address fields of the incoming request
  logic [cache_pkg::tag_width-1:0]     req_tag;
  logic [cache_pkg::line_ix_width-1:0] req_idx;
  logic [cache_pkg::word_ix_width-1:0] req_word;

  // per line bookkeeping
  logic [cache_pkg::num_lines-1:0] valid_q;
  logic [cache_pkg::tag_width-1:0] tags [cache_pkg::num_lines];

  // all lines in one array, addressed by {line, word}
  logic [cache_pkg::instr_width-1:0] lines [cache_pkg::num_lines * cache_pkg::words_per_line];

  // line being filled
  logic [cache_pkg::tag_width-1:0]     fill_tag;
  logic [cache_pkg::line_ix_width-1:0] fill_idx;
  logic [cache_pkg::beat_ix_width-1:0] beat_cnt;

  // word to present on instr
  logic [store_ix_width-1:0] rd_ix_q;

  logic rdy_q;
  logic busy_q;
  logic cmd_q;
  logic accept;
  logic lookup_hit;

  assign req_tag  = addr_b[cache_pkg::instr_addr_width-1 -: cache_pkg::tag_width];
  assign req_idx  = addr_b[cache_pkg::word_ix_width +: cache_pkg::line_ix_width];
  assign req_word = addr_b[cache_pkg::word_ix_width-1:0];

  // busy is low in idle and deliver, requests are taken in both
  assign accept = enable && !busy_q;

  // in deliver the new tag is not written yet, so forward the fill line
  assign lookup_hit = (valid_q[req_idx] && tags[req_idx] == req_tag) ||
                      (state == cache_pkg::deliver && req_idx == fill_idx &&
                       req_tag == fill_tag);

  // control FSM
  always_ff @(posedge clk_cpu) begin
    if (rst) begin
      state    <= cache_pkg::idle;
      valid_q  <= '0;
      beat_cnt <= '0;
      rdy_q    <= 1'b0;
      busy_q   <= 1'b0;
      cmd_q    <= 1'b0;
    end else begin
      // pulses by default
      rdy_q <= 1'b0;
      cmd_q <= 1'b0;
      case (state)
        cache_pkg::idle, cache_pkg::deliver: begin
          state <= cache_pkg::idle;
          // line is complete, mark it
          if (state == cache_pkg::deliver) begin
            valid_q[fill_idx] <= 1'b1;
          end
          if (accept) begin
            if (lookup_hit) begin
              rdy_q <= 1'b1;
            end else begin
              // line gets overwritten, drop it now
              // comes after the set above so a refill of the same line wins
              valid_q[req_idx] <= 1'b0;
              busy_q           <= 1'b1;
              state            <= cache_pkg::request;
            end
          end
        end
        cache_pkg::request: begin
          // burst ram takes one command at a time
          if (!br_busy) begin
            cmd_q    <= 1'b1;
            beat_cnt <= '0;
            state    <= cache_pkg::receive;
          end
        end
        cache_pkg::receive: begin
          // no back-pressure, every valid beat is taken
          if (br_rd_data_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == cache_pkg::beat_ix_width'(cache_pkg::burst_count - 1)) begin
              // last beat, answer in deliver
              rdy_q  <= 1'b1;
              busy_q <= 1'b0;
              state  <= cache_pkg::deliver;
            end
          end
        end
        default: begin
          state <= cache_pkg::idle;
        end
      endcase
    end
  end

  // request fields and tags
  always_ff @(posedge clk_cpu) begin
    if (state == cache_pkg::deliver) begin
      tags[fill_idx] <= fill_tag;
    end
    if (accept) begin
      rd_ix_q <= {req_idx, req_word};
      if (!lookup_hit) begin
        fill_tag <= req_tag;
        fill_idx <= req_idx;
      end
    end
  end

  // line storage, one beat holds instr_per_beat words, low half first
  always_ff @(posedge clk_cpu) begin
    if (state == cache_pkg::receive && br_rd_data_valid) begin
      for (int h = 0; h < cache_pkg::instr_per_beat; h++) begin
        lines[{fill_idx, beat_cnt, half_width'(h)}] <=
          br_rd_data[h*cache_pkg::instr_width +: cache_pkg::instr_width];
      end
    end
  end

  // outputs
  assign instr      = lines[rd_ix_q];
  assign data_ready = rdy_q;
  assign busy       = busy_q;
  assign br_cmd_en  = cmd_q;
  // line address in the burst ram is tag | index
  assign br_addr    = {fill_tag, fill_idx};

endmodule

//--- ram_init.hex
// burst ram image, one 64-bit entry per line, entry line*4+k is beat k of that line
// columns: high 32 bits = instruction 2*entry+1, low 32 bits = instruction 2*entry
3e01a5931f00c013
7203b1b70a02f293
5c05e2a3c104d037
0b0714b39806a863
e309b06f2608c193
4a0b7e13d50a3c03
1c0dd8e7670c0293
f00f2233880e91b7
3411a423a9104f93
6b13cc630d125013
92151e83c4147d37
2f1769b355162a93
d81983e701188813
7a1bf7a3b61a1e63
0e1d24b3831c5c17
c61fb1ef4e1e9893
2921d033f3200c93
9523688b6e2247a3
4c2532131a24e9b7
b7279e63d826052f
03294d836528b3e3
e82bc2b34f2a1893
572d0a17a12c7513
8c2f6d63362ebfb3
1d31e993c9304203
f13324a37a328e6f
6235b8b30c34d113
a83713e7db366c37
4539fd9326385013
cb3b2863913a9a23
083dc5b3743cb213
b93f6113ed3e3e93

//--- sources.f
cache_pkg.sv
data_ram.sv
icache.sv
burst_ram.sv
cache.sv
tb_cache.sv

//--- tb_cache.sv
/*
  testbench for the cpu memory subsystem, runs from the project root
  expected instructions come from ram_init.hex, port A from a byte-merged model
  stops at the first error, every wait has its own cycle limit
*/
module tb_cache;

  logic        clk_cpu;
  logic        rst;
  logic [3:0]  we;
  logic [7:0]  addr_a;
  logic [31:0] din_a;
  logic [31:0] dout_a;
  logic        enable;
  logic [5:0]  addr_b;
  logic [31:0] instr;
  logic        data_ready;
  logic        busy;

  // reference image, same layout as the burst ram
  logic [63:0] image [32];
  // port A model and which words hold fully defined data
  logic [31:0] data_model [256];
  bit          known [256];
  // an accepted fetch that has not been answered yet
  logic        fetch_open;
  integer      seed;

  cache UUT (
    .clk_cpu    (clk_cpu),
    .rst        (rst),
    .we         (we),
    .addr_a     (addr_a),
    .din_a      (din_a),
    .dout_a     (dout_a),
    .enable     (enable),
    .addr_b     (addr_b),
    .instr      (instr),
    .data_ready (data_ready),
    .busy       (busy)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #4 clk_cpu = ~clk_cpu;
  end

  // stop the run after printing what went wrong
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_value(input string msg);
    stop_run($sformatf("[FAIL] t=%0t %s", $time, msg));
  endtask

  task automatic report_timeout(input string what);
    stop_run($sformatf("timed out after %0t waiting for %s", $time, what));
  endtask

  // one clock, then the drive point 1 unit after the edge
  task automatic tick();
    @(posedge clk_cpu);
    #1;
  endtask

  // bookkeeping for the data_ready check
  always @(posedge clk_cpu) begin
    if (rst) begin
      fetch_open <= 1'b0;
    end else begin
      if (data_ready) begin
        fetch_open <= 1'b0;
      end
      // a new request in the answer cycle wins
      if (enable && !busy) begin
        fetch_open <= 1'b1;
      end
    end
  end

  // every answer needs a request that was taken
  assert property (@(posedge clk_cpu) disable iff (rst) data_ready |-> fetch_open)
    else report_value("data_ready without a preceding enable");

  // busy drops in the same cycle as the answer
  assert property (@(posedge clk_cpu) disable iff (rst) data_ready |-> !busy)
    else report_value("busy still high while data_ready pulses");

  // instruction w is half of entry w/2, bit 0 picks the half
  function automatic logic [31:0] expected_instr(input logic [5:0] w);
    logic [63:0] entry;
    entry = image[w[5:1]];
    if (w[0]) begin
      return entry[63:32];
    end else begin
      return entry[31:0];
    end
  endfunction

  // one port A cycle, be == 0 is a plain read
  // dout_a must show the word as it was before this cycle's write
  task automatic access_a(input logic [7:0] a, input logic [31:0] d, input logic [3:0] be);
    logic [31:0] old;
    old = data_model[a];
    we = be;
    addr_a = a;
    din_a = d;
    tick();
    we = 4'h0;
    if (known[a]) begin
      assert (dout_a == old)
        else report_value($sformatf("port A addr %0d read %h expected %h", a, dout_a, old));
    end
    for (int b = 0; b < cache_pkg::num_col; b++) begin
      if (be[b]) begin
        data_model[a][b*cache_pkg::col_width +: cache_pkg::col_width] =
          d[b*cache_pkg::col_width +: cache_pkg::col_width];
      end
    end
    if (be == 4'hf) begin
      known[a] = 1'b1;
    end
  endtask

  // requests may only go out while busy is low
  task automatic wait_idle();
    int n;
    n = 0;
    while (busy) begin
      if (n >= 50) begin
        report_timeout("busy to fall before a fetch");
      end
      tick();
      n++;
    end
  endtask

  // one port B fetch, optionally checking that it hits or misses
  task automatic fetch(input logic [5:0] w, input bit want_hit, input bit want_miss);
    logic [31:0] exp;
    int lat;
    wait_idle();
    exp = expected_instr(w);
    enable = 1'b1;
    addr_b = w;
    tick();
    enable = 1'b0;
    lat = 1;
    if (want_hit) begin
      assert (data_ready && !busy)
        else report_value($sformatf("fetch %0d expected a hit one cycle after enable", w));
    end
    if (want_miss) begin
      assert (busy && !data_ready)
        else report_value($sformatf("fetch %0d expected busy on the cycle after enable", w));
    end
    while (!data_ready) begin
      if (lat >= 50) begin
        report_timeout($sformatf("data_ready of fetch %0d", w));
      end
      tick();
      lat++;
    end
    assert (instr == exp)
      else report_value($sformatf("fetch %0d instr %h expected %h", w, instr, exp));
    // enable, command, latency, beats, deliver
    if (want_miss) begin
      assert (lat >= 1 + cache_pkg::burst_read_latency + cache_pkg::burst_count + 1)
        else report_value($sformatf("fetch %0d miss answered after only %0d cycles", w, lat));
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [7:0]  a;
    logic [7:0]  a_list [$];
    seed = 32'hb3abdf3c;
    rst = 1'b1;
    we = 4'h0;
    addr_a = 8'h00;
    din_a = 32'h0;
    enable = 1'b0;
    addr_b = 6'h00;
    $readmemh("ram_init.hex", image);
    repeat (4) tick();
    rst = 1'b0;
    assert (!busy && !data_ready)
      else report_value("busy or data_ready high after reset");
    repeat (3) tick();

    // port A, full words at 16 distinct addresses
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      a = {i[3:0], rnd[3:0]};
      a_list.push_back(a);
      rnd = $random(seed);
      access_a(a, rnd, 4'hf);
    end
    // partial lane writes, each also checks the old word comes back
    foreach (a_list[i]) begin
      rnd = $random(seed);
      access_a(a_list[i], rnd, rnd[3:0] ^ rnd[7:4]);
    end
    // plain reads against the merged model
    foreach (a_list[i]) begin
      access_a(a_list[i], 32'h0, 4'h0);
    end

    // first fetch into each cache line misses
    fetch(6'd2, 1'b0, 1'b1);
    fetch(6'd9, 1'b0, 1'b1);
    // other words of the loaded lines hit
    fetch(6'd5, 1'b1, 1'b0);
    fetch(6'd14, 1'b1, 1'b0);
    fetch(6'd7, 1'b1, 1'b0);
    // same index, tag 2, evicts line 0
    fetch(6'd34, 1'b0, 1'b1);
    fetch(6'd39, 1'b1, 1'b0);
    fetch(6'd2, 1'b0, 1'b1);
    // line 1 was not touched by the conflict
    fetch(6'd9, 1'b1, 1'b0);
    fetch(6'd63, 1'b0, 1'b1);

    // random fetches, hit or miss not predicted
    for (int i = 0; i < 200; i++) begin
      rnd = $random(seed);
      fetch(rnd[5:0], 1'b0, 1'b0);
    end

    repeat (4) tick();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
